// File: source/cgra_defines.svh
`ifndef CGRA_DEFINES_SVH
`define CGRA_DEFINES_SVH

// ****************************************
// array slice sizing
// ****************************************

// number of reconfigurable regions
`define CGRA_NUM_PRR 2

// region field at the top of a config address
`define CGRA_PRR_ID_WIDTH 1

`define CGRA_CFG_ADDR_WIDTH 8
`define CGRA_CFG_DATA_WIDTH 32
`define CGRA_CFG_DEPTH 16

// stream side
`define CGRA_WORD_WIDTH 16
`define CGRA_RESULT_DEPTH 4

`endif

// File: source/cgra_cfg_pkg.sv
`include "cgra_defines.svh"

package cgra_cfg_pkg;

    typedef logic [`CGRA_CFG_ADDR_WIDTH-1:0] cfg_addr_t;
    typedef logic [`CGRA_CFG_DATA_WIDTH-1:0] cfg_data_t;

    // register index, low bits of an address
    typedef logic [$clog2(`CGRA_CFG_DEPTH)-1:0] cfg_idx_t;

    // region number, top bits of an address
    typedef logic [`CGRA_PRR_ID_WIDTH-1:0] prr_id_t;

    typedef enum logic [1:0] {
        op_pass = 2'd0,
        op_add  = 2'd1,
        op_xor  = 2'd2,
        op_mul  = 2'd3
    } prr_op_e;

    // control fields decoded from registers 0 to 2
    typedef struct packed {
        logic                        glb2prr_on;
        logic                        prr2glb_on;
        prr_op_e                     op;
        logic [`CGRA_WORD_WIDTH-1:0] operand;
    } prr_ctrl_t;

endpackage

// File: source/cgra_stream_pkg.sv
`include "cgra_defines.svh"

package cgra_stream_pkg;

    // data word moved between global buffer and regions
    typedef logic [`CGRA_WORD_WIDTH-1:0] word_t;

    // valid-only handshake, taken on any edge with valid high
    typedef struct packed {
        logic  valid;
        word_t data;
    } beat_t;

endpackage

// File: source/prr_cfg_decode.sv
`timescale 1ns/1ps
`include "cgra_defines.svh"

module prr_cfg_decode #(
    parameter int prr_index = 0
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wr_en,
    input  cgra_cfg_pkg::cfg_addr_t wr_addr,
    input  cgra_cfg_pkg::cfg_data_t wr_data,
    input  logic                    rd_en,
    input  cgra_cfg_pkg::cfg_addr_t rd_addr,
    output cgra_cfg_pkg::cfg_data_t rd_data,
    input  logic                    overflow,
    output cgra_cfg_pkg::prr_ctrl_t ctrl
);
    import cgra_cfg_pkg::*;

    localparam prr_id_t  own_id     = prr_id_t'(prr_index);
    localparam cfg_idx_t status_idx = cfg_idx_t'(3);

    // register map
    //   0     bit 0 glb2prr_on, bit 1 prr2glb_on
    //   1     bits 1:0 opcode
    //   2     bits 15:0 operand
    //   3     status, bit 0 sticky overflow, any write clears
    //   4-15  scratch
    cfg_data_t regs [`CGRA_CFG_DEPTH];

    logic     wr_hit;
    logic     rd_hit;
    cfg_idx_t wr_idx;
    cfg_idx_t rd_idx;

    assign wr_hit = wr_en && (wr_addr[`CGRA_CFG_ADDR_WIDTH-1 -: `CGRA_PRR_ID_WIDTH] == own_id);
    assign rd_hit = rd_en && (rd_addr[`CGRA_CFG_ADDR_WIDTH-1 -: `CGRA_PRR_ID_WIDTH] == own_id);
    assign wr_idx = wr_addr[$bits(cfg_idx_t)-1:0];
    assign rd_idx = rd_addr[$bits(cfg_idx_t)-1:0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `CGRA_CFG_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr_hit) begin
                if (wr_idx == status_idx) begin
                    regs[status_idx] <= '0;
                end else begin
                    regs[wr_idx] <= wr_data;
                end
            end
            // a drop in the clearing cycle still sets the flag
            if (overflow) begin
                regs[status_idx][0] <= 1'b1;
            end
        end
    end

    always_comb begin
        rd_data = rd_hit ? regs[rd_idx] : '0;
    end

    always_comb begin
        ctrl.glb2prr_on = regs[0][0];
        ctrl.prr2glb_on = regs[0][1];
        ctrl.op         = prr_op_e'(regs[1][1:0]);
        ctrl.operand    = regs[2][`CGRA_WORD_WIDTH-1:0];
    end

endmodule

// File: source/prr_execute.sv
`timescale 1ns/1ps

module prr_execute (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall,
    input  cgra_stream_pkg::beat_t  in_beat,
    input  cgra_cfg_pkg::prr_ctrl_t ctrl,
    output cgra_stream_pkg::beat_t  out_beat
);
    import cgra_cfg_pkg::*;
    import cgra_stream_pkg::*;

    logic  accept;
    word_t result;
    logic  valid_q;
    word_t data_q;

    // beat taken only with input streaming on and no stall
    assign accept = in_beat.valid && ctrl.glb2prr_on && !stall;

    always_comb begin
        case (ctrl.op)
            op_add: begin
                result = in_beat.data + ctrl.operand;
            end
            op_xor: begin
                result = in_beat.data ^ ctrl.operand;
            end
            op_mul: begin
                // low half of the product
                result = in_beat.data * ctrl.operand;
            end
            default: begin
                result = in_beat.data;
            end
        endcase
    end

    // single stage, holds while stalled
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= result;
        end
    end

    assign out_beat = '{valid: valid_q, data: data_q};

endmodule

// File: source/prr_result_fifo.sv
`timescale 1ns/1ps
`include "cgra_defines.svh"

module prr_result_fifo (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stall,
    input  cgra_stream_pkg::beat_t in_beat,
    input  logic                   out_en,
    output cgra_stream_pkg::beat_t out_beat,
    output logic                   overflow
);
    import cgra_stream_pkg::*;

    localparam int               ptr_w = $clog2(`CGRA_RESULT_DEPTH);
    localparam logic [ptr_w:0]   depth = (ptr_w + 1)'(`CGRA_RESULT_DEPTH);
    localparam logic [ptr_w-1:0] last  = ptr_w'(`CGRA_RESULT_DEPTH - 1);

    word_t            mem [`CGRA_RESULT_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             push;
    logic             pop;
    logic             valid_q;
    word_t            data_q;

    // ****************************************
    // push and pop decisions
    // ****************************************
    assign pop      = out_en && !stall && (count != '0);
    // a pop in the same cycle frees a slot
    assign push     = in_beat.valid && !stall && ((count != depth) || pop);
    assign overflow = in_beat.valid && !stall && (count == depth) && !pop;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == last) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == last) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_beat.data;
        end
    end

    // ****************************************
    // registered output beat
    // ****************************************
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            data_q <= mem[rd_ptr];
        end
    end

    assign out_beat = '{valid: valid_q, data: data_q};

endmodule

// File: source/cgra.sv
`timescale 1ns/1ps
`include "cgra_defines.svh"

module cgra (
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic                    [`CGRA_NUM_PRR-1:0]       stall,

    // configuration port, one per region
    input  logic                    [`CGRA_NUM_PRR-1:0]       cfg_wr_en,
    input  cgra_cfg_pkg::cfg_addr_t [`CGRA_NUM_PRR-1:0]       cfg_wr_addr,
    input  cgra_cfg_pkg::cfg_data_t [`CGRA_NUM_PRR-1:0]       cfg_wr_data,
    input  logic                    [`CGRA_NUM_PRR-1:0]       cfg_rd_en,
    input  cgra_cfg_pkg::cfg_addr_t [`CGRA_NUM_PRR-1:0]       cfg_rd_addr,
    output cgra_cfg_pkg::cfg_data_t [`CGRA_NUM_PRR-1:0]       cfg_rd_data,

    // streams to and from the global buffer
    input  cgra_stream_pkg::beat_t  [`CGRA_NUM_PRR-1:0]       g2io,
    output cgra_stream_pkg::beat_t  [`CGRA_NUM_PRR-1:0]       io2g
);
    import cgra_cfg_pkg::*;
    import cgra_stream_pkg::*;

    // ****************************************
    // one slice per region
    // ****************************************
    for (genvar r = 0; r < `CGRA_NUM_PRR; r++) begin : g_prr
        prr_ctrl_t ctrl;
        logic      overflow;
        beat_t     exe_beat;

        prr_cfg_decode #(
            .prr_index (r)
        ) i_decode (
            .clk      (clk),
            .reset    (reset),
            .wr_en    (cfg_wr_en[r]),
            .wr_addr  (cfg_wr_addr[r]),
            .wr_data  (cfg_wr_data[r]),
            .rd_en    (cfg_rd_en[r]),
            .rd_addr  (cfg_rd_addr[r]),
            .rd_data  (cfg_rd_data[r]),
            .overflow (overflow),
            .ctrl     (ctrl)
        );

        prr_execute i_execute (
            .clk      (clk),
            .reset    (reset),
            .stall    (stall[r]),
            .in_beat  (g2io[r]),
            .ctrl     (ctrl),
            .out_beat (exe_beat)
        );

        // output gated by the prr2glb bit
        prr_result_fifo i_result (
            .clk      (clk),
            .reset    (reset),
            .stall    (stall[r]),
            .in_beat  (exe_beat),
            .out_en   (ctrl.prr2glb_on),
            .out_beat (io2g[r]),
            .overflow (overflow)
        );
    end

endmodule

// File: tb/cgra_props.sv
`timescale 1ns/1ps

module cgra_props (
    input logic                   clk,
    input logic                   reset,
    input logic                   stall,
    input logic                   out_en,
    input cgra_stream_pkg::beat_t out_beat
);

    // ****************************************
    // output stream properties
    // ****************************************

    // quiet while in reset and on the first edge after it
    reset_quiet: assert property (@(posedge clk) reset |-> !out_beat.valid)
        else $error("output valid while reset is high");

    reset_release: assert property (@(posedge clk) reset |=> !out_beat.valid)
        else $error("output valid right after reset");

    stall_hold: assert property (@(posedge clk) disable iff (reset)
        stall |=> $stable(out_beat))
        else $error("output beat changed during a stall");

    // prr2glb off and no stall means no new word
    output_off: assert property (@(posedge clk) disable iff (reset)
        (!out_en && !stall) |=> !out_beat.valid)
        else $error("output word while output streaming is off");

endmodule

bind prr_result_fifo cgra_props i_props (
    .clk      (clk),
    .reset    (reset),
    .stall    (stall),
    .out_en   (out_en),
    .out_beat (out_beat)
);

// File: tb/cgra_tb.sv
`timescale 1ns/1ps
`include "cgra_defines.svh"

module cgra_tb;
    import cgra_cfg_pkg::*;
    import cgra_stream_pkg::*;

    localparam int n = `CGRA_NUM_PRR;
    localparam int clk_period = 40;
    localparam int op_beats = 24;
    localparam int stall_beats = 64;
    // idle, four opcodes, stall, overflow, input off
    localparam int total_beats = (8 + 4 * op_beats + stall_beats + 6 + 8) * n;
    localparam int watchdog_cycles = total_beats * 20 + 200;

    logic              clk = 1'b0;
    logic              reset;
    logic [n-1:0]      stall, cfg_wr_en, cfg_rd_en;
    cfg_addr_t [n-1:0] cfg_wr_addr, cfg_rd_addr;
    cfg_data_t [n-1:0] cfg_wr_data, cfg_rd_data;
    beat_t [n-1:0]     g2io, io2g;

    logic [31:0] lfsr = 32'hd1f3_de89;
    cfg_data_t   shadow [n][`CGRA_CFG_DEPTH];
    logic [n-1:0] exp_ovf;
    word_t       exp_q [n][$];
    int          seen [n];
    string       test_name;

    cgra i_dut (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .cfg_wr_en   (cfg_wr_en),
        .cfg_wr_addr (cfg_wr_addr),
        .cfg_wr_data (cfg_wr_data),
        .cfg_rd_en   (cfg_rd_en),
        .cfg_rd_addr (cfg_rd_addr),
        .cfg_rd_data (cfg_rd_data),
        .g2io        (g2io),
        .io2g        (io2g)
    );

    always #(clk_period / 2) clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    function automatic word_t ref_op(input prr_op_e op, input word_t operand, input word_t din);
        logic [31:0] product;
        product = {16'b0, din} * {16'b0, operand};
        case (op)
            op_add: return din + operand;
            op_xor: return din ^ operand;
            op_mul: return product[15:0];
            default: return din;
        endcase
    endfunction

    function automatic cfg_addr_t make_addr(input int region, input int idx);
        cfg_addr_t addr;
        addr = '0;
        addr[`CGRA_CFG_ADDR_WIDTH-1 -: `CGRA_PRR_ID_WIDTH] = prr_id_t'(region);
        addr[$bits(cfg_idx_t)-1:0] = cfg_idx_t'(idx);
        return addr;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s, %s: expected %h, actual %h", test_name, what, expected, actual);
            $display("** FAIL **");
            $fatal(1, "value check failed");
        end
    endtask

    // register map: 0 stream bits, 1 opcode, 2 operand, 3 status, 4-15 scratch
    task automatic cfg_write(input int port, input int region, input int idx, input cfg_data_t data);
        @(negedge clk);
        cfg_wr_en[port] = 1'b1;
        cfg_wr_addr[port] = make_addr(region, idx);
        cfg_wr_data[port] = data;
        if (region == port && idx == 3) begin
            exp_ovf[port] = 1'b0;
        end else if (region == port) begin
            shadow[port][idx] = data;
        end
        @(negedge clk);
        cfg_wr_en[port] = 1'b0;
    endtask

    task automatic read_check(input int port, input int region, input int idx,
                              input cfg_data_t expected);
        cfg_data_t got;
        @(negedge clk);
        cfg_rd_en[port] = 1'b1;
        cfg_rd_addr[port] = make_addr(region, idx);
        @(posedge clk);
        got = cfg_rd_data[port];
        check_value($sformatf("port %0d region %0d reg %0d", port, region, idx), expected, got);
        @(negedge clk);
        cfg_rd_en[port] = 1'b0;
    endtask

    task automatic read_all(input int r);
        for (int i = 0; i < `CGRA_CFG_DEPTH; i++) begin
            read_check(r, r, i, (i == 3) ? {31'b0, exp_ovf[r]} : shadow[r][i]);
        end
    endtask

    // ****************************************
    // stimulus and model queues
    // ****************************************
    task automatic stream(input int cycles, input bit use_stall, input bit always_valid);
        logic [31:0] rnd;
        logic        take;
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            for (int r = 0; r < n; r++) begin
                rnd = take_bits(20);
                g2io[r].valid = always_valid || (rnd[19:18] != 2'b00);
                g2io[r].data = rnd[15:0];
                stall[r] = use_stall && (rnd[17:16] == 2'b00);
                take = g2io[r].valid && !stall[r] && shadow[r][0][0];
                // full queue with output off drops the word
                if (take && !shadow[r][0][1] && exp_q[r].size() >= `CGRA_RESULT_DEPTH) begin
                    exp_ovf[r] = 1'b1;
                end else if (take) begin
                    exp_q[r].push_back(ref_op(prr_op_e'(shadow[r][1][1:0]),
                                              shadow[r][2][15:0], rnd[15:0]));
                end
            end
        end
        @(negedge clk);
        g2io = '0;
        stall = '0;
    endtask

    task automatic drain();
        for (int r = 0; r < n; r++) begin
            while (exp_q[r].size() != 0) @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    // a word is taken on an edge with valid high and no stall
    always @(posedge clk) begin
        word_t want;
        if (!reset) begin
            for (int r = 0; r < n; r++) begin
                if (io2g[r].valid && !stall[r] && exp_q[r].size() == 0) begin
                    $display("region %0d sent word %h that was never expected", r, io2g[r].data);
                    $display("** FAIL **");
                    $fatal(1, "unexpected output word");
                end else if (io2g[r].valid && !stall[r]) begin
                    want = exp_q[r].pop_front();
                    check_value($sformatf("region %0d word %0d", r, seen[r]),
                                32'(want), 32'(io2g[r].data));
                    seen[r]++;
                end
            end
        end
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("timeout: run still busy after %0d cycles", watchdog_cycles);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int leftover;
        reset = 1'b1;
        stall = '0;
        cfg_wr_en = '0;
        cfg_wr_addr = '0;
        cfg_wr_data = '0;
        cfg_rd_en = '0;
        cfg_rd_addr = '0;
        g2io = '0;
        exp_ovf = '0;
        for (int r = 0; r < n; r++) begin
            for (int i = 0; i < `CGRA_CFG_DEPTH; i++) begin
                shadow[r][i] = '0;
            end
        end
        test_name = "reset state";
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int r = 0; r < n; r++) begin
            read_all(r);
        end
        stream(8, 1'b0, 1'b0);
        drain();

        test_name = "config registers";
        for (int r = 0; r < n; r++) begin
            for (int i = 4; i < `CGRA_CFG_DEPTH; i++) begin
                cfg_write(r, r, i, take_bits(32));
            end
            // other region named, must be ignored
            cfg_write(r, (r + 1) % n, 4 + take_bits(3), take_bits(32));
        end
        for (int r = 0; r < n; r++) begin
            read_all(r);
            read_check(r, (r + 1) % n, 5, '0);
        end

        for (int k = 0; k < 4; k++) begin
            test_name = $sformatf("opcode %0d", k);
            for (int r = 0; r < n; r++) begin
                cfg_write(r, r, 1, (k + r) % 4);
                cfg_write(r, r, 2, take_bits(16));
                cfg_write(r, r, 0, 3);
            end
            stream(op_beats, 1'b0, 1'b0);
            drain();
        end

        test_name = "stall";
        stream(stall_beats, 1'b1, 1'b0);
        drain();

        test_name = "overflow";
        for (int r = 0; r < n; r++) begin
            cfg_write(r, r, 0, 1);
        end
        stream(6, 1'b0, 1'b1);
        repeat (4) @(negedge clk);
        for (int r = 0; r < n; r++) begin
            cfg_write(r, r, 0, 3);
        end
        drain();
        for (int r = 0; r < n; r++) begin
            read_check(r, r, 3, 1);
            cfg_write(r, r, 3, 0);
            read_check(r, r, 3, 0);
        end

        test_name = "input off";
        // queue would overflow if any beat got in
        for (int r = 0; r < n; r++) begin
            cfg_write(r, r, 0, 0);
        end
        stream(8, 1'b0, 1'b1);
        for (int r = 0; r < n; r++) begin
            cfg_write(r, r, 0, 2);
        end
        repeat (6) @(negedge clk);
        for (int r = 0; r < n; r++) begin
            read_check(r, r, 3, 0);
        end

        leftover = 0;
        for (int r = 0; r < n; r++) begin
            leftover += exp_q[r].size();
        end
        if (leftover == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("%0d expected words never came out", leftover);
            $display("** FAIL **");
            $fatal(1, "words left in the model queues");
        end
    end

endmodule

// File: vlog.f
+incdir+source
source/cgra_cfg_pkg.sv
source/cgra_stream_pkg.sv
source/prr_cfg_decode.sv
source/prr_execute.sv
source/prr_result_fifo.sv
source/cgra.sv
tb/cgra_props.sv
tb/cgra_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and check the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module cgra_tb -f vlog.f -o cgra_sim \
    || { echo "build failed"; exit 1; }
sim_error=""
./obj_dir/cgra_sim > sim.log 2>&1 || sim_error=1
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && { echo "simulation failed"; exit 1; }
[ -z "$sim_error" ] || { echo "simulator exited with an error"; exit 1; }
echo "simulation passed"
exit 0
